// ==== logic/bit_sampler.sv ====
//////////////////////////////////////////////////////////////////////
// receive pin front end
// two-flop synchronizer, start-edge detect and
// majority vote over the samples of one bit window
//////////////////////////////////////////////////////////////////////

`default_nettype none

module bit_sampler (
    input  logic clk,
    input  logic rst,
    input  logic rx_pin,
    input  logic idle,
    input  logic sample_stb,
    input  logic bit_end,
    output logic start_seen,
    output logic bit_value
);
    import uart_rx_pkg::*;

    // synchronizer, line idles high
    logic [1:0] sync_q;
    logic       rx_sync;
    // high samples seen in this window
    logic [2:0] hi_cnt;

    assign rx_sync = sync_q[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], rx_pin};
        end
    end

    // low line while the frame FSM waits
    assign start_seen = idle && !rx_sync;

    //////////////////////////////////////////////////////////////////////
    // vote
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_cnt <= '0;
        end else if (bit_end || idle) begin
            // cleared on the same bit_end that reads it
            hi_cnt <= '0;
        end else if (sample_stb && rx_sync) begin
            hi_cnt <= hi_cnt + 3'd1;
        end
    end

    // only meaningful on bit_end
    assign bit_value = (hi_cnt >= 3'(VOTE_MAJORITY));

    // timer gives at most 7 strobes a window, so the count never wraps
    a_count_bound : assert property (
        @(posedge clk) disable iff (rst)
        (sample_stb && rx_sync && !bit_end && !idle) |-> (hi_cnt < 3'(SAMPLE_COUNT))
    ) else $error("bit_sampler high count exceeds sample count");

endmodule

`default_nettype wire

// ==== logic/bit_timer.sv ====
//////////////////////////////////////////////////////////////////////
// bit window timer
// sample strobes at the slot boundaries of each bit window,
// end-of-bit strobe on the last clock of the window
//////////////////////////////////////////////////////////////////////

`default_nettype none

module bit_timer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            run,
    input  logic [uart_rx_pkg::PERIOD_W-1:0] bit_period,
    output logic                            sample_stb,
    output logic                            bit_end
);
    import uart_rx_pkg::*;

    localparam int unsigned SLOT_W = PERIOD_W - SAMPLE_SHIFT;

    // clocks into the current bit window
    logic [PERIOD_W-1:0] bit_cnt;
    // clocks into the current slot
    logic [SLOT_W-1:0]   slot_cnt;
    // slot boundaries already passed in this window
    logic [2:0]          slot_idx;
    // slot length, bit_period / 8
    logic [SLOT_W-1:0]   slot_len;
    logic                slot_wrap;

    assign slot_len  = bit_period[PERIOD_W-1:SAMPLE_SHIFT];
    assign slot_wrap = (slot_cnt == slot_len - 1'b1);

    // no gating by run here, the reload keeps both strobes quiet
    assign bit_end    = (bit_cnt == bit_period - 1'b1);
    assign sample_stb = slot_wrap && (slot_idx != 3'(SAMPLE_COUNT));

    //////////////////////////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            bit_cnt  <= '0;
            slot_cnt <= '0;
            slot_idx <= '0;
        end else if (bit_end) begin
            // next window starts fresh
            bit_cnt  <= '0;
            slot_cnt <= '0;
            slot_idx <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
            if (slot_wrap) begin
                slot_cnt <= '0;
            end else begin
                slot_cnt <= slot_cnt + 1'b1;
            end
            // holds at 7 when the period is not a multiple of 8
            if (sample_stb) begin
                slot_idx <= slot_idx + 3'd1;
            end
        end
    end

    // strobes stay quiet between frames, relies on bit_period >= 16
    a_quiet_when_stopped : assert property (
        @(posedge clk) disable iff (rst)
        !run |-> !(sample_stb || bit_end)
    ) else $error("bit_timer strobe while run is low");

endmodule

`default_nettype wire

// ==== logic/rx_frame_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// frame state machine of the receiver
// latches the settings, shifts in data LSB first,
// tracks parity and issues data, ready, error and busy
//////////////////////////////////////////////////////////////////////

`default_nettype none

module rx_frame_fsm (
    input  logic                             clk,
    input  logic                             rst,
    input  uart_rx_pkg::uart_cfg_t           cfg,
    input  logic                             start_seen,
    input  logic                             bit_end,
    input  logic                             bit_value,
    output logic                             idle,
    output logic                             timer_run,
    output logic [uart_rx_pkg::PERIOD_W-1:0] bit_period,
    output uart_rx_pkg::data_t               data,
    output logic                             ready,
    output logic                             error,
    output logic                             busy
);
    import uart_rx_pkg::*;

    rx_state_t  state;
    // settings of the frame in flight
    uart_cfg_t  cfg_q;
    // data bits enter at the top
    data_t      shift_q;
    logic [3:0] bit_cnt;
    logic       stop_cnt;
    // xor of data and parity bits
    logic       parity_q;

    logic       last_data;
    logic       last_stop;
    logic       frame_done;
    logic       parity_err;
    // right shift that aligns the word
    logic [3:0] align_sh;

    assign idle       = (state == ST_IDLE);
    assign timer_run  = (state != ST_IDLE);
    assign bit_period = cfg_q.bit_period;

    assign last_data  = ((bit_cnt + 4'd1) >= cfg_q.data_bits);
    assign last_stop  = (stop_cnt == cfg_q.stop_bits);
    assign frame_done = (state == ST_STOP) && bit_end && last_stop;
    assign align_sh   = 4'(DATA_W) - cfg_q.data_bits;

    // odd parity wants an odd count of ones over data and parity bit
    always_comb begin
        case (cfg_q.parity)
            PARITY_NONE: parity_err = 1'b0;
            PARITY_ODD:  parity_err = !parity_q;
            PARITY_EVEN: parity_err = parity_q;
            default:     parity_err = 1'b1;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // settings latch
    //////////////////////////////////////////////////////////////////////

    // zero period keeps the timer quiet after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (idle && start_seen) begin
            cfg_q <= cfg;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
            parity_q <= 1'b0;
            ready    <= 1'b0;
            error    <= 1'b0;
            busy     <= 1'b0;
        end else begin
            // one-cycle strobes
            ready <= 1'b0;
            error <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_seen) begin
                        state    <= ST_START;
                        busy     <= 1'b1;
                        bit_cnt  <= '0;
                        parity_q <= 1'b0;
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        if (bit_value) begin
                            // false start when the line went back high
                            state <= ST_IDLE;
                            busy  <= 1'b0;
                        end else begin
                            state <= ST_DATA;
                        end
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        parity_q <= parity_q ^ bit_value;
                        bit_cnt  <= bit_cnt + 4'd1;
                        if (last_data) begin
                            stop_cnt <= 1'b0;
                            if (cfg_q.parity == PARITY_NONE) begin
                                state <= ST_STOP;
                            end else begin
                                state <= ST_PARITY;
                            end
                        end
                    end
                end
                ST_PARITY: begin
                    if (bit_end) begin
                        parity_q <= parity_q ^ bit_value;
                        stop_cnt <= 1'b0;
                        state    <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    // stop level is not checked
                    if (frame_done) begin
                        state <= ST_IDLE;
                        busy  <= 1'b0;
                        ready <= 1'b1;
                        error <= parity_err;
                    end else if (bit_end) begin
                        stop_cnt <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // data path
    //////////////////////////////////////////////////////////////////////

    // LSB first so each bit enters at the top
    always_ff @(posedge clk) begin
        if ((state == ST_DATA) && bit_end) begin
            shift_q <= {bit_value, shift_q[DATA_W-1:1]};
        end
    end

    // stale low bits drop out and upper bits fill with zero
    always_ff @(posedge clk) begin
        if (rst) begin
            data <= '0;
        end else if (frame_done) begin
            data <= shift_q >> align_sh;
        end
    end

    // strobes only follow the bit_end of the last stop window
    a_strobe_at_frame_end : assert property (
        @(posedge clk) disable iff (rst)
        (ready || error) |-> $past((state == ST_STOP) && bit_end && last_stop)
    ) else $error("rx_frame_fsm ready or error outside the last stop window");

    // busy register tracks the state register
    a_busy_not_idle : assert property (
        @(posedge clk) disable iff (rst)
        (state == ST_IDLE) |-> !busy
    ) else $error("rx_frame_fsm busy high while idle");

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
//////////////////////////////////////////////////////////////////////
// serial receiver top level
// bit timer, pin sampler and frame FSM
//////////////////////////////////////////////////////////////////////

`default_nettype none

module uart_rx (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rx_pin,
    input  uart_rx_pkg::uart_cfg_t cfg,
    output uart_rx_pkg::data_t     data,
    output logic                   ready,
    output logic                   error,
    output logic                   busy
);
    import uart_rx_pkg::*;

    // sampler to FSM
    logic                start_seen;
    logic                bit_value;
    // FSM to sampler and timer
    logic                idle;
    logic                timer_run;
    logic [PERIOD_W-1:0] bit_period;
    // timer strobes
    logic                sample_stb;
    logic                bit_end;

    bit_timer i_bit_timer (
        .clk        (clk),
        .rst        (rst),
        .run        (timer_run),
        .bit_period (bit_period),
        .sample_stb (sample_stb),
        .bit_end    (bit_end)
    );

    bit_sampler i_bit_sampler (
        .clk        (clk),
        .rst        (rst),
        .rx_pin     (rx_pin),
        .idle       (idle),
        .sample_stb (sample_stb),
        .bit_end    (bit_end),
        .start_seen (start_seen),
        .bit_value  (bit_value)
    );

    rx_frame_fsm i_rx_frame_fsm (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .start_seen (start_seen),
        .bit_end    (bit_end),
        .bit_value  (bit_value),
        .idle       (idle),
        .timer_run  (timer_run),
        .bit_period (bit_period),
        .data       (data),
        .ready      (ready),
        .error      (error),
        .busy       (busy)
    );

endmodule

`default_nettype wire

// ==== logic/uart_rx_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types and constants for the serial receiver
// line settings struct, parity and stop-bit codes,
// frame states and oversampling constants
//////////////////////////////////////////////////////////////////////

`default_nettype none

package uart_rx_pkg;

    // widths
    localparam int unsigned PERIOD_W = 16;
    localparam int unsigned DATA_W   = 8;

    // bit window split into 2**SAMPLE_SHIFT slots
    localparam int unsigned SAMPLE_SHIFT  = 3;
    // slot boundaries 1..7 are sampled
    localparam int unsigned SAMPLE_COUNT  = 7;
    // high samples needed for a one
    localparam int unsigned VOTE_MAJORITY = 4;

    // parity codes
    localparam logic [1:0] PARITY_NONE = 2'd0;
    localparam logic [1:0] PARITY_ODD  = 2'd1;
    localparam logic [1:0] PARITY_EVEN = 2'd2;
    // reserved code, always flags an error
    localparam logic [1:0] PARITY_BAD  = 2'd3;

    // stop-bit codes
    localparam logic STOP_ONE = 1'b0;
    localparam logic STOP_TWO = 1'b1;

    typedef logic [DATA_W-1:0] data_t;

    // line settings, 23 bits
    typedef struct packed {
        // clocks per bit, 16 or more
        logic [PERIOD_W-1:0] bit_period;
        // 1 to 8
        logic [3:0]          data_bits;
        logic [1:0]          parity;
        logic                stop_bits;
    } uart_cfg_t;

    // frame states
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_START  = 3'd1,
        ST_DATA   = 3'd2,
        ST_PARITY = 3'd3,
        ST_STOP   = 3'd4
    } rx_state_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the receiver testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_uart_rx \
    && ./obj_dir/Vtb_uart_rx | tee /dev/stderr | grep -F "All tests passed!" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verif/tb_uart_rx.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the serial receiver
// clock, reset, random frames and glitches, reference model,
// checker hookup and cycle timeout
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_uart_rx;
    import uart_rx_pkg::*;

    localparam int N_FRAMES = 200;
    localparam int MAX_BP   = 64;
    // worst iteration is a glitch with its gap plus a 14-window frame
    localparam int CYCLE_LIMIT = N_FRAMES * (17 * MAX_BP + 20) + 100;

    logic      clk;
    logic      rst;
    logic      rx_pin;
    uart_cfg_t cfg;
    data_t     data;
    logic      ready;
    logic      error;
    logic      busy;
    // model to checker
    logic      exp_push;
    data_t     exp_data;
    logic      exp_error;
    logic      frame_start;
    logic      end_check;
    int        err_count;
    int        cycles = 0;

    uart_rx i_uart_rx (
        .clk    (clk),
        .rst    (rst),
        .rx_pin (rx_pin),
        .cfg    (cfg),
        .data   (data),
        .ready  (ready),
        .error  (error),
        .busy   (busy)
    );

    uart_rx_checker i_checker (
        .clk         (clk),
        .rst         (rst),
        .data        (data),
        .ready       (ready),
        .error       (error),
        .busy        (busy),
        .exp_push    (exp_push),
        .exp_data    (exp_data),
        .exp_error   (exp_error),
        .frame_start (frame_start),
        .end_check   (end_check),
        .err_count   (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d errors so far", cycles, err_count);
            $display("Test failures found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // keep the low n bits
    function automatic data_t mask_word(data_t d, logic [3:0] n);
        data_t m;
        m = '0;
        repeat (n) m = {m[DATA_W-2:0], 1'b1};
        return d & m;
    endfunction

    // odd parity makes the ones of data plus parity bit odd
    function automatic logic parity_bit(data_t d, logic [1:0] par);
        if (par == PARITY_ODD) return ~(^d);
        return ^d;
    endfunction

    function automatic uart_cfg_t random_cfg();
        uart_cfg_t c;
        c.bit_period = 16'(16 + $urandom % (MAX_BP - 15));
        c.data_bits  = 4'(1 + $urandom % 8);
        c.parity     = 2'($urandom % 4);
        c.stop_bits  = 1'($urandom % 2);
        return c;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // line driver, all changes on the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic hold_line(logic level, int unsigned n);
        rx_pin = level;
        repeat (n) @(negedge clk);
    endtask

    task automatic send_frame(uart_cfg_t c, data_t d, logic flip, logic scramble);
        data_t       word;
        data_t       sh;
        logic        pbit;
        int unsigned bp;
        word      = mask_word(d, c.data_bits);
        sh        = word;
        pbit      = parity_bit(word, c.parity) ^ flip;
        bp        = 32'(c.bit_period);
        cfg       = c;
        exp_data  = word;
        // the bad code fails whatever the parity bit is
        exp_error = (c.parity == PARITY_BAD) || ((c.parity != PARITY_NONE) && flip);
        exp_push    = 1'b1;
        frame_start = 1'b1;
        hold_line(1'b0, 1);
        exp_push    = 1'b0;
        frame_start = 1'b0;
        repeat (bp - 1) @(negedge clk);
        // settings latched a few clocks into the start bit
        if (scramble) cfg = random_cfg();
        // LSB first
        repeat (c.data_bits) begin
            hold_line(sh[0], bp);
            sh = sh >> 1;
        end
        if (c.parity != PARITY_NONE) hold_line(pbit, bp);
        // stop windows plus two idle periods
        hold_line(1'b1, bp * (3 + 32'(c.stop_bits)));
    endtask

    // low pulse of at most an eighth of a bit
    task automatic send_glitch(uart_cfg_t c);
        int unsigned bp;
        bp  = 32'(c.bit_period);
        cfg = c;
        hold_line(1'b0, 1 + $urandom % (bp / 8));
        hold_line(1'b1, 2 * bp);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        uart_cfg_t c;
        data_t     d;
        rst         = 1'b1;
        rx_pin      = 1'b1;
        cfg         = '0;
        exp_push    = 1'b0;
        exp_data    = '0;
        exp_error   = 1'b0;
        frame_start = 1'b0;
        end_check   = 1'b0;
        void'($urandom(32'h5aa437cb));
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        for (int i = 0; i < N_FRAMES; i++) begin
            c = random_cfg();
            d = 8'($urandom);
            if (i % 8 == 3) send_glitch(c);
            // some frames get a flipped parity bit, some a cfg change mid frame
            send_frame(c, d, (i % 5 == 1), (i % 4 == 2));
        end
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        @(negedge clk);
        $display("errors: %0d", err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/uart_rx_checker.sv ====
//////////////////////////////////////////////////////////////////////
// receiver checker
// expected frame queue, data and error compares,
// reset values and busy checks
//////////////////////////////////////////////////////////////////////

`default_nettype none

module uart_rx_checker (
    input  logic               clk,
    input  logic               rst,
    input  uart_rx_pkg::data_t data,
    input  logic               ready,
    input  logic               error,
    input  logic               busy,
    input  logic               exp_push,
    input  uart_rx_pkg::data_t exp_data,
    input  logic               exp_error,
    input  logic               frame_start,
    input  logic               end_check,
    output int                 err_count
);
    import uart_rx_pkg::*;

    // {error, data} of each frame in flight
    logic [DATA_W:0] exp_q[$];
    logic [DATA_W:0] head;
    logic            rst_q = 1'b0;
    logic            in_frame = 1'b0;
    // clocks since the start bit went out
    int              frame_cyc = 0;
    int              errs = 0;

    assign err_count = errs;

    task automatic check_value(string name, logic [DATA_W-1:0] exp,
                               logic [DATA_W-1:0] act);
        if (exp !== act) begin
            errs++;
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(string what);
        errs++;
        $display("failure at %0t: %s", $time, what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // compares, sampled on the rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            in_frame = 1'b0;
        end else begin
            // first clock out of reset
            if (rst_q) begin
                check_value("data", '0, data);
                check_value("ready", '0, 8'(ready));
                check_value("error", '0, 8'(error));
                check_value("busy", '0, 8'(busy));
            end
            if (exp_push) exp_q.push_back({exp_error, exp_data});
            if (frame_start) begin
                if (busy) report_failure("busy is high on the idle line before a frame");
                in_frame  = 1'b1;
                frame_cyc = 0;
            end else if (in_frame) begin
                frame_cyc++;
            end
            // synchronizer plus state register, busy is up by the 4th clock
            if (in_frame && frame_cyc >= 4 && !busy && !ready)
                report_failure("busy dropped inside a frame before ready");
            if (error && !ready) report_failure("error pulse came without ready");
            if (ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("ready came with no frame expected");
                end else begin
                    head = exp_q.pop_front();
                    check_value("data", head[DATA_W-1:0], data);
                    check_value("error", 8'(head[DATA_W]), 8'(error));
                end
                in_frame = 1'b0;
            end
            if (end_check) begin
                if (exp_q.size() != 0) report_failure("frames still waiting for ready at the end");
                if (busy) report_failure("busy is high on the idle line at the end");
            end
        end
        rst_q = rst;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/uart_rx_pkg.sv
logic/bit_timer.sv
logic/bit_sampler.sv
logic/rx_frame_fsm.sv
logic/uart_rx.sv
verif/uart_rx_checker.sv
verif/tb_uart_rx.sv
